// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pistorm_bridge
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= All tests passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/access_fsm.sv
`timescale 1ns/1ps

module access_fsm (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            clk_rising,
    input  logic                            clk_falling,
    input  logic                            is_bm,
    input  logic                            req_active,
    input  logic                            req_rw,
    input  logic [bridge_pkg::ADDR_W-1:0]   req_address,
    input  bridge_pkg::req_size_t           req_size,
    input  logic [2:0]                      req_fc,
    input  logic [bridge_pkg::DATA_W-1:0]   req_data_write,
    input  logic [1:0]                      dsack_n,
    input  logic                            berr_n,
    input  bridge_pkg::port_width_t         port_width,
    output logic [bridge_pkg::ADDR_W-1:0]   mc_address,
    output logic [2:0]                      mc_fc,
    output logic [1:0]                      mc_size,
    output logic                            mc_rw,
    output logic                            mc_as_n,
    output logic                            mc_ds_n,
    output logic                            mc_data_oe,
    output logic [bridge_pkg::DATA_W-1:0]   mc_data_out,
    output logic                            merge_load,
    output logic [1:0]                      merge_shift,
    output bridge_pkg::req_size_t           cur_size,
    output logic                            done,
    output logic                            terminated_normally
);
    typedef enum logic [2:0] {
        ST_IDLE, ST_S0, ST_S1, ST_S2, ST_S3, ST_TERM, ST_S5, ST_NEXT
    } state_t;

    state_t                        state;
    logic [bridge_pkg::ADDR_W-1:0] address;
    logic                          rw;
    logic [2:0]                    fc;
    logic [bridge_pkg::DATA_W-1:0] data_write;
    logic                          term_ok;
    logic [1:0]                    xfer;   // Bytes moved this cycle, minus one.
    logic [1:0]                    left_shift;
    logic                          any_termination;
    logic [bridge_pkg::DATA_W-1:0] steered;

    assign left_shift      = address[1:0] & port_width;
    assign any_termination = (dsack_n != 2'b11) || !berr_n;

    write_steer write_steer_inst (
        .operand (data_write),
        .size    (cur_size),
        .offset  (address[1:0]),
        .lanes   (steered)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state               <= ST_IDLE;
            mc_as_n             <= 1'b1;
            mc_ds_n             <= 1'b1;
            mc_data_oe          <= 1'b0;
            merge_load          <= 1'b0;
            done                <= 1'b0;
            terminated_normally <= 1'b0;
        end else begin
            merge_load <= 1'b0;
            done       <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req_active && is_bm && !done) begin
                        address    <= req_address;
                        cur_size   <= req_size;
                        rw         <= req_rw;
                        fc         <= req_fc;
                        data_write <= req_data_write;
                        state      <= ST_S0;
                    end
                end
                ST_S0: begin
                    if (clk_rising) begin
                        mc_address  <= address;
                        mc_fc       <= fc;
                        mc_rw       <= rw;
                        mc_size     <= cur_size + 2'd1;   // Table 5-2, four wraps to 00.
                        mc_data_out <= steered;
                        state       <= ST_S1;
                    end
                end
                ST_S1: begin
                    if (clk_falling) begin
                        mc_as_n <= 1'b0;
                        if (rw)
                            mc_ds_n <= 1'b0;
                        state <= ST_S2;
                    end
                end
                ST_S2: begin
                    if (clk_rising) begin
                        mc_data_oe <= !rw;
                        state      <= rw ? ST_TERM : ST_S3;
                    end
                end
                ST_S3: begin
                    if (clk_falling) begin
                        mc_ds_n <= 1'b0;   // Write data has settled.
                        state   <= ST_TERM;
                    end
                end
                ST_TERM: begin
                    if (any_termination) begin
                        term_ok <= berr_n;
                        state   <= ST_S5;
                    end
                end
                ST_S5: begin
                    if (clk_falling) begin
                        mc_as_n     <= 1'b1;
                        mc_ds_n     <= 1'b1;
                        mc_data_oe  <= 1'b0;
                        merge_load  <= rw;
                        merge_shift <= left_shift;
                        xfer        <= port_width - left_shift;
                        state       <= ST_NEXT;
                    end
                end
                default: begin
                    // Dynamic sizing, run another cycle for what the port left over.
                    if (term_ok && cur_size > xfer) begin
                        address  <= address + {{(bridge_pkg::ADDR_W-2){1'b0}}, xfer} + 1'b1;
                        cur_size <= cur_size - xfer - 2'd1;
                        state    <= ST_S0;
                    end else begin
                        done                <= 1'b1;
                        terminated_normally <= term_ok;
                        state               <= ST_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: logic/bridge_pkg.sv
package bridge_pkg;

    localparam int ADDR_W = 24;
    localparam int DATA_W = 32;
    localparam int LANE_W = 8;
    localparam int LANES  = DATA_W / LANE_W;   // Byte lanes on the data bus.
    localparam int PI_W   = 16;
    localparam int PI_A_W = 3;

    // Pi register window. Status is read and control written at the same address.
    localparam logic [PI_A_W-1:0] REG_DATA_LO = 3'd0;
    localparam logic [PI_A_W-1:0] REG_DATA_HI = 3'd1;
    localparam logic [PI_A_W-1:0] REG_ADDR_LO = 3'd2;
    localparam logic [PI_A_W-1:0] REG_ADDR_HI = 3'd3;
    localparam logic [PI_A_W-1:0] REG_STATUS  = 3'd4;

    // Control register bits.
    localparam int CTRL_W           = 5;
    localparam int CTRL_REQUEST_BM  = 0;
    localparam int CTRL_DRIVE_RESET = 1;
    localparam int CTRL_DRIVE_HALT  = 2;
    localparam int CTRL_DRIVE_INT2  = 3;
    localparam int CTRL_DRIVE_INT6  = 4;
    localparam logic [CTRL_W-1:0] CTRL_RESET_VALUE = 5'b00110;   // Hold the CPU in reset.

    // Status register bits.
    localparam int STATUS_IS_BM   = 0;
    localparam int STATUS_TERM_OK = 1;
    localparam int STATUS_ACTIVE  = 2;

    // Byte count minus one.
    typedef logic [1:0] req_size_t;

    // Port width as decoded from DSACK.
    typedef logic [1:0] port_width_t;
    localparam port_width_t PORT_8  = 2'd0;
    localparam port_width_t PORT_16 = 2'd1;
    localparam port_width_t PORT_32 = 2'd3;

endpackage

// File: logic/bus_sampler.sv
`timescale 1ns/1ps

module bus_sampler (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            mc_clk,
    input  logic                            mc_bg_n,
    input  logic                            mc_as_n_in,
    input  logic                            request_bm,
    input  logic [1:0]                      mc_dsack_n,
    input  logic                            mc_berr_n,
    input  logic [bridge_pkg::DATA_W-1:0]   mc_data_in,
    output logic                            clk_rising,
    output logic                            clk_falling,
    output logic                            is_bm,
    output logic [1:0]                      dsack_n,
    output logic                            berr_n,
    output bridge_pkg::port_width_t         port_width,
    output logic [bridge_pkg::DATA_W-1:0]   data_sampled
);
    logic [2:0] mc_clk_sync;   // Two sync stages, then one for edge history.
    logic       bg_sync;
    logic       as_sync;

    always_ff @(posedge clk) begin
        mc_clk_sync <= {mc_clk_sync[1:0], mc_clk};
        if (reset) begin
            clk_rising  <= 1'b0;
            clk_falling <= 1'b0;
        end else begin
            clk_rising  <= mc_clk_sync[1] & ~mc_clk_sync[2];
            clk_falling <= ~mc_clk_sync[1] & mc_clk_sync[2];
        end
    end

    // Mastership once granted and the previous owner has let go of AS.
    always_ff @(posedge clk) begin
        bg_sync <= ~mc_bg_n;
        as_sync <= ~mc_as_n_in;
        if (reset || !request_bm)
            is_bm <= 1'b0;
        else if (bg_sync && !as_sync)
            is_bm <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dsack_n <= 2'b11;
            berr_n  <= 1'b1;
        end else if (clk_falling) begin
            dsack_n <= mc_dsack_n;
            berr_n  <= mc_berr_n;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_falling)
            data_sampled <= mc_data_in;
    end

    // Table 5-1.
    always_comb begin
        case (dsack_n)
            2'b01:   port_width = bridge_pkg::PORT_16;
            2'b00:   port_width = bridge_pkg::PORT_32;
            default: port_width = bridge_pkg::PORT_8;   // 2'b11 means no ack yet.
        endcase
    end

endmodule

// File: logic/pi_regs.sv
`timescale 1ns/1ps

module pi_regs (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            pi_wr,
    input  logic [bridge_pkg::PI_A_W-1:0]   pi_a,
    input  logic [bridge_pkg::PI_W-1:0]     pi_d_in,
    output logic [bridge_pkg::PI_W-1:0]     pi_d_out,
    input  logic                            done,
    input  logic                            terminated_normally,
    input  logic [bridge_pkg::DATA_W-1:0]   read_data,
    input  logic                            is_bm,
    output logic                            req_active,
    output logic                            req_rw,
    output logic [bridge_pkg::ADDR_W-1:0]   req_address,
    output bridge_pkg::req_size_t           req_size,
    output logic [2:0]                      req_fc,
    output logic [bridge_pkg::DATA_W-1:0]   req_data_write,
    output logic                            request_bm,
    output logic                            drive_reset,
    output logic                            drive_halt,
    output logic                            drive_int2,
    output logic                            drive_int6
);
    logic [bridge_pkg::CTRL_W-1:0] control;
    logic                          term_ok;
    logic [bridge_pkg::DATA_W-1:0] result;
    logic [bridge_pkg::PI_W-1:0]   status;

    assign request_bm  = control[bridge_pkg::CTRL_REQUEST_BM];
    assign drive_reset = control[bridge_pkg::CTRL_DRIVE_RESET];
    assign drive_halt  = control[bridge_pkg::CTRL_DRIVE_HALT];
    assign drive_int2  = control[bridge_pkg::CTRL_DRIVE_INT2];
    assign drive_int6  = control[bridge_pkg::CTRL_DRIVE_INT6];

    always_ff @(posedge clk) begin
        if (reset) begin
            control    <= bridge_pkg::CTRL_RESET_VALUE;
            req_active <= 1'b0;
            term_ok    <= 1'b0;
        end else begin
            if (done) begin
                req_active <= 1'b0;
                term_ok    <= terminated_normally;
            end
            if (pi_wr && pi_a == bridge_pkg::REG_ADDR_HI)
                req_active <= 1'b1;   // Request goes live with its last half.
            if (pi_wr && pi_a == bridge_pkg::REG_STATUS) begin
                if (pi_d_in[15])
                    control <= control | pi_d_in[bridge_pkg::CTRL_W-1:0];
                else
                    control <= control & ~pi_d_in[bridge_pkg::CTRL_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done)
            result <= read_data;
        if (pi_wr) begin
            case (pi_a)
                bridge_pkg::REG_DATA_LO: req_data_write[bridge_pkg::PI_W-1:0] <= pi_d_in;
                bridge_pkg::REG_DATA_HI:
                    req_data_write[bridge_pkg::DATA_W-1:bridge_pkg::PI_W] <= pi_d_in;
                bridge_pkg::REG_ADDR_LO: req_address[bridge_pkg::PI_W-1:0] <= pi_d_in;
                bridge_pkg::REG_ADDR_HI: begin
                    req_address[bridge_pkg::ADDR_W-1:bridge_pkg::PI_W] <= pi_d_in[7:0];
                    req_size <= pi_d_in[9:8];
                    req_rw   <= pi_d_in[10];   // 1 is a read.
                    req_fc   <= pi_d_in[13:11];
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        status = '0;
        status[bridge_pkg::STATUS_IS_BM]   = is_bm;
        status[bridge_pkg::STATUS_TERM_OK] = term_ok;
        status[bridge_pkg::STATUS_ACTIVE]  = req_active;
    end

    always_comb begin
        case (pi_a)
            bridge_pkg::REG_DATA_LO: pi_d_out = result[bridge_pkg::PI_W-1:0];
            bridge_pkg::REG_DATA_HI: pi_d_out = result[bridge_pkg::DATA_W-1:bridge_pkg::PI_W];
            bridge_pkg::REG_ADDR_LO: pi_d_out = req_address[bridge_pkg::PI_W-1:0];
            bridge_pkg::REG_ADDR_HI:
                pi_d_out = {2'b00, req_fc, req_rw, req_size,
                            req_address[bridge_pkg::ADDR_W-1:bridge_pkg::PI_W]};
            bridge_pkg::REG_STATUS:  pi_d_out = status;
            default:                 pi_d_out = '0;
        endcase
    end

endmodule

// File: logic/pistorm_bridge.sv
`timescale 1ns/1ps

module pistorm_bridge (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            pi_wr,
    input  logic [bridge_pkg::PI_A_W-1:0]   pi_a,
    input  logic [bridge_pkg::PI_W-1:0]     pi_d_in,
    output logic [bridge_pkg::PI_W-1:0]     pi_d_out,
    input  logic                            mc_clk,
    input  logic                            mc_bg_n,
    input  logic                            mc_as_n_in,
    input  logic [1:0]                      mc_dsack_n,
    input  logic                            mc_berr_n,
    input  logic [bridge_pkg::DATA_W-1:0]   mc_data_in,
    output logic [bridge_pkg::ADDR_W-1:0]   mc_address,
    output logic [2:0]                      mc_fc,
    output logic [1:0]                      mc_size,
    output logic                            mc_rw,
    output logic                            mc_as_n,
    output logic                            mc_ds_n,
    output logic                            mc_data_oe,
    output logic [bridge_pkg::DATA_W-1:0]   mc_data_out,
    output logic                            mc_bus_oe,
    output logic                            mc_br_n,
    output logic                            mc_reset_n_oe,
    output logic                            mc_halt_n_oe,
    output logic                            int2_n_oe,
    output logic                            int6_n_oe
);
    logic                          clk_rising;
    logic                          clk_falling;
    logic                          is_bm;
    logic [1:0]                    dsack_n;
    logic                          berr_n;
    bridge_pkg::port_width_t       port_width;
    logic [bridge_pkg::DATA_W-1:0] data_sampled;
    logic                          req_active;
    logic                          req_rw;
    logic [bridge_pkg::ADDR_W-1:0] req_address;
    bridge_pkg::req_size_t         req_size;
    logic [2:0]                    req_fc;
    logic [bridge_pkg::DATA_W-1:0] req_data_write;
    logic                          request_bm;
    logic                          done;
    logic                          terminated_normally;
    logic                          merge_load;
    logic [1:0]                    merge_shift;
    bridge_pkg::req_size_t         cur_size;
    logic [bridge_pkg::DATA_W-1:0] read_data;

    assign mc_bus_oe = is_bm;
    assign mc_br_n   = ~request_bm;   // Bus request, low while mastership is wanted.

    bus_sampler bus_sampler_inst (
        .clk          (clk),
        .reset        (reset),
        .mc_clk       (mc_clk),
        .mc_bg_n      (mc_bg_n),
        .mc_as_n_in   (mc_as_n_in),
        .request_bm   (request_bm),
        .mc_dsack_n   (mc_dsack_n),
        .mc_berr_n    (mc_berr_n),
        .mc_data_in   (mc_data_in),
        .clk_rising   (clk_rising),
        .clk_falling  (clk_falling),
        .is_bm        (is_bm),
        .dsack_n      (dsack_n),
        .berr_n       (berr_n),
        .port_width   (port_width),
        .data_sampled (data_sampled)
    );

    pi_regs pi_regs_inst (
        .clk                 (clk),
        .reset               (reset),
        .pi_wr               (pi_wr),
        .pi_a                (pi_a),
        .pi_d_in             (pi_d_in),
        .pi_d_out            (pi_d_out),
        .done                (done),
        .terminated_normally (terminated_normally),
        .read_data           (read_data),
        .is_bm               (is_bm),
        .req_active          (req_active),
        .req_rw              (req_rw),
        .req_address         (req_address),
        .req_size            (req_size),
        .req_fc              (req_fc),
        .req_data_write      (req_data_write),
        .request_bm          (request_bm),
        .drive_reset         (mc_reset_n_oe),
        .drive_halt          (mc_halt_n_oe),
        .drive_int2          (int2_n_oe),
        .drive_int6          (int6_n_oe)
    );

    access_fsm access_fsm_inst (
        .clk                 (clk),
        .reset               (reset),
        .clk_rising          (clk_rising),
        .clk_falling         (clk_falling),
        .is_bm               (is_bm),
        .req_active          (req_active),
        .req_rw              (req_rw),
        .req_address         (req_address),
        .req_size            (req_size),
        .req_fc              (req_fc),
        .req_data_write      (req_data_write),
        .dsack_n             (dsack_n),
        .berr_n              (berr_n),
        .port_width          (port_width),
        .mc_address          (mc_address),
        .mc_fc               (mc_fc),
        .mc_size             (mc_size),
        .mc_rw               (mc_rw),
        .mc_as_n             (mc_as_n),
        .mc_ds_n             (mc_ds_n),
        .mc_data_oe          (mc_data_oe),
        .mc_data_out         (mc_data_out),
        .merge_load          (merge_load),
        .merge_shift         (merge_shift),
        .cur_size            (cur_size),
        .done                (done),
        .terminated_normally (terminated_normally)
    );

    read_merge read_merge_inst (
        .clk       (clk),
        .reset     (reset),
        .load      (merge_load),
        .size      (cur_size),
        .shift     (merge_shift),
        .lanes     (data_sampled),
        .read_data (read_data)
    );

endmodule

// File: logic/read_merge.sv
`timescale 1ns/1ps

module read_merge (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          load,
    input  bridge_pkg::req_size_t         size,
    input  logic [1:0]                    shift,
    input  logic [bridge_pkg::DATA_W-1:0] lanes,
    output logic [bridge_pkg::DATA_W-1:0] read_data
);
    logic [bridge_pkg::DATA_W-1:0] merged;

    // Table 5-4. Result byte i takes lane size - i + shift, lane 0 being bits 31:24.
    // Bytes past the port are refilled by a later bus cycle.
    always_comb begin
        int lane;
        merged = read_data;
        for (int i = 0; i < bridge_pkg::LANES; i++) begin
            lane = int'(size) - i + int'(shift);
            if (i <= int'(size) && lane < bridge_pkg::LANES)
                merged[i*bridge_pkg::LANE_W +: bridge_pkg::LANE_W] =
                    lanes[(bridge_pkg::LANES-1-lane)*bridge_pkg::LANE_W +: bridge_pkg::LANE_W];
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            read_data <= '0;
        else if (load)
            read_data <= merged;   // Earlier partial bytes stay put.
    end

endmodule

// File: logic/write_steer.sv
`timescale 1ns/1ps

module write_steer (
    input  logic [bridge_pkg::DATA_W-1:0] operand,
    input  bridge_pkg::req_size_t         size,
    input  logic [1:0]                    offset,
    output logic [bridge_pkg::DATA_W-1:0] lanes
);
    // b0 is the least significant operand byte.
    logic [bridge_pkg::LANE_W-1:0] b0;
    logic [bridge_pkg::LANE_W-1:0] b1;
    logic [bridge_pkg::LANE_W-1:0] b2;
    logic [bridge_pkg::LANE_W-1:0] b3;

    assign {b3, b2, b1, b0} = operand;

    // Table 5-5, with unused lanes filled by a copy.
    always_comb begin
        case (size)
            2'd0: lanes = {b0, b0, b0, b0};
            2'd1: lanes = offset[0] ? {b1, b1, b0, b1} : {b1, b0, b1, b0};
            2'd2: begin
                case (offset)
                    2'd0:    lanes = {b2, b1, b0, b0};
                    2'd1:    lanes = {b2, b2, b1, b0};
                    2'd2:    lanes = {b2, b1, b2, b1};
                    default: lanes = {b2, b2, b1, b2};
                endcase
            end
            default: begin
                case (offset)
                    2'd0:    lanes = {b3, b2, b1, b0};
                    2'd1:    lanes = {b3, b3, b2, b1};
                    2'd2:    lanes = {b3, b2, b3, b2};
                    default: lanes = {b3, b3, b2, b3};
                endcase
            end
        endcase
    end

endmodule

// File: test/pistorm_bridge_assert.sv
`timescale 1ns/1ps

module pistorm_bridge_assert (
    input logic        clk,
    input logic        reset,
    input logic        mc_as_n,
    input logic        mc_ds_n,
    input logic [23:0] mc_address,
    input logic        mc_bus_oe
);

    // Data strobe only inside an address strobe.
    ds_within_as: assert property (@(posedge clk) disable iff (reset) mc_as_n |-> mc_ds_n)
        else $error("ds_n low while as_n high");

    address_stable: assert property (@(posedge clk) disable iff (reset)
        (!mc_as_n && !$past(mc_as_n)) |-> $stable(mc_address))
        else $error("mc_address changed during a bus cycle");

    // No cycles without the bus.
    as_needs_bus: assert property (@(posedge clk) disable iff (reset) !mc_bus_oe |-> mc_as_n)
        else $error("as_n low without bus mastership");

endmodule

bind pistorm_bridge pistorm_bridge_assert pistorm_bridge_assert_inst (
    .clk        (clk),
    .reset      (reset),
    .mc_as_n    (mc_as_n),
    .mc_ds_n    (mc_ds_n),
    .mc_address (mc_address),
    .mc_bus_oe  (mc_bus_oe)
);

// File: test/tb_pistorm_bridge.sv
`timescale 1ns/1ps

module tb_pistorm_bridge;

    localparam int NUM_ROWS  = 97;   // 96 size/offset/port rows plus one bus error.
    localparam int MEM_BYTES = 64;
    localparam int LIMIT     = NUM_ROWS * 400 + 200;
    localparam logic [2:0] FC_CODE = 3'b101;   // Supervisor data space.

    typedef struct {
        logic [23:0] addr;
        logic [1:0]  size;
        logic        rw;
        logic [31:0] wdata;
        logic [1:0]  port;
        logic        berr;
        logic [31:0] expected;
    } row_t;

    logic        clk;
    logic        reset;
    logic        pi_wr;
    logic [2:0]  pi_a;
    logic [15:0] pi_d_in;
    logic [15:0] pi_d_out;
    logic        mc_clk;
    logic        mc_bg_n;
    logic        mc_as_n_in;
    logic [1:0]  mc_dsack_n;
    logic        mc_berr_n;
    logic [31:0] mc_data_in;
    logic [23:0] mc_address;
    logic [2:0]  mc_fc;
    logic [1:0]  mc_size;
    logic        mc_rw;
    logic        mc_as_n;
    logic        mc_ds_n;
    logic        mc_data_oe;
    logic [31:0] mc_data_out;
    logic        mc_bus_oe;
    logic        mc_br_n;
    logic        mc_reset_n_oe;
    logic        mc_halt_n_oe;
    logic        int2_n_oe;
    logic        int6_n_oe;

    row_t        rows[NUM_ROWS];
    logic [7:0]  mem[MEM_BYTES];
    logic [7:0]  snap[MEM_BYTES];
    logic [1:0]  cur_port;   // Port width the slave answers with.
    logic        cur_berr;
    logic        cur_rw;
    int          cycles;
    int          div;
    int          ack_cnt;
    int          bus_cycles;
    int          width;
    int          base;
    int          off;
    int          nbytes;
    logic [31:0] lanes;

    pistorm_bridge pistorm_bridge_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Bus clock at a quarter of clk.
    always @(posedge clk) begin
        div <= div + 1;
        if (div % 2 == 1)
            mc_clk <= ~mc_clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles, the bridge stopped responding.", cycles);
            $display("Some tests failed");
            $fatal(1, "timeout");
        end
    end

    // 68020 slave memory, answering one bus clock after the strobes fall.
    always @(posedge clk) begin
        mc_bg_n <= mc_br_n;   // Grant whenever asked.
        if (mc_as_n) begin
            ack_cnt    <= 0;
            mc_dsack_n <= 2'b11;
            mc_berr_n  <= 1'b1;
        end else if (!mc_ds_n) begin
            if (ack_cnt == 3) begin
                check("mc_fc", {29'd0, mc_fc}, {29'd0, FC_CODE});
                check("mc_rw", {31'd0, mc_rw}, {31'd0, cur_rw});
                check("mc_data_oe", {31'd0, mc_data_oe}, {31'd0, !cur_rw});
                bus_cycles <= bus_cycles + 1;
                width  = (cur_port == bridge_pkg::PORT_32) ? 4 :
                         (cur_port == bridge_pkg::PORT_16) ? 2 : 1;
                base   = int'(mc_address[5:0]) & ~(width - 1);
                off    = int'(mc_address[5:0]) - base;
                nbytes = (mc_size == 2'd0) ? 4 : int'(mc_size);
                lanes  = '0;
                for (int k = 0; k < width; k++) begin
                    lanes[31-8*k -: 8] = mem[base+k];   // Lane 0 is bits 31:24.
                    if (!mc_rw && !cur_berr && k >= off && k < off + nbytes)
                        mem[base+k] <= mc_data_out[31-8*k -: 8];
                end
                if (cur_berr)
                    mc_berr_n <= 1'b0;
                else begin
                    mc_data_in <= lanes;
                    mc_dsack_n <= (width == 4) ? 2'b00 : (width == 2) ? 2'b01 : 2'b10;
                end
            end
            if (ack_cnt < 4)
                ack_cnt <= ack_cnt + 1;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("Some tests failed");
            $fatal(1, "mismatch");
        end
    endtask

    // One Pi register cycle. Read data is taken mid-cycle.
    task automatic pi_access(input logic wr, input logic [2:0] a, input logic [15:0] d,
                             output logic [15:0] q);
        @(posedge clk);
        pi_wr   <= wr;
        pi_a    <= a;
        pi_d_in <= d;
        @(posedge clk);
        pi_wr <= 1'b0;
        @(negedge clk);
        q = pi_d_out;
    endtask

    task automatic run_row(input row_t r);
        logic [15:0] q;
        logic [15:0] lo;
        logic [31:0] mask;
        logic [31:0] exp_b;
        int          first;
        int          start_cycles;
        cur_port     = r.port;
        cur_berr     = r.berr;
        cur_rw       = r.rw;
        snap         = mem;
        mask         = 32'hffff_ffff >> (8 * (3 - int'(r.size)));
        first        = int'(r.addr);
        start_cycles = bus_cycles;
        pi_access(1'b1, bridge_pkg::REG_DATA_LO, r.wdata[15:0], q);
        pi_access(1'b1, bridge_pkg::REG_DATA_HI, r.wdata[31:16], q);
        pi_access(1'b1, bridge_pkg::REG_ADDR_LO, r.addr[15:0], q);
        pi_access(1'b1, bridge_pkg::REG_ADDR_HI, {2'b00, FC_CODE, r.rw, r.size, r.addr[23:16]}, q);
        do
            pi_access(1'b0, bridge_pkg::REG_STATUS, 16'h0000, q);
        while (q[2]);
        check("status_term_ok", {31'd0, q[1]}, {31'd0, !r.berr});
        if (r.berr)
            check("bus_cycles", 32'(bus_cycles - start_cycles), 32'd1);   // No retry after BERR.
        if (!r.berr && r.rw) begin
            pi_access(1'b0, bridge_pkg::REG_DATA_LO, 16'h0000, lo);
            pi_access(1'b0, bridge_pkg::REG_DATA_HI, 16'h0000, q);
            check("read_data", {q, lo} & mask, r.expected);
        end else if (!r.berr) begin
            for (int j = 0; j < MEM_BYTES; j++) begin
                if (j >= first && j <= first + int'(r.size))
                    exp_b = (r.expected >> (8 * (int'(r.size) - (j - first)))) & 32'hff;
                else
                    exp_b = {24'd0, snap[j]};   // Neighbors keep their value.
                check($sformatf("mem[%0d]", j), {24'd0, mem[j]}, exp_b);
            end
        end
    endtask

    initial begin
        logic [15:0] q;
        logic [1:0]  ports[3];
        int          idx;
        reset      = 1'b1;
        pi_wr      = 1'b0;
        pi_a       = '0;
        pi_d_in    = '0;
        mc_clk     = 1'b0;
        mc_bg_n    = 1'b1;
        mc_as_n_in = 1'b1;   // No other master on the bus.
        mc_dsack_n = 2'b11;
        mc_berr_n  = 1'b1;
        mc_data_in = '0;
        cycles     = 0;
        div        = 0;
        ack_cnt    = 0;
        bus_cycles = 0;
        cur_port   = bridge_pkg::PORT_32;
        cur_berr   = 1'b0;
        cur_rw     = 1'b1;
        ports[0]   = bridge_pkg::PORT_8;
        ports[1]   = bridge_pkg::PORT_16;
        ports[2]   = bridge_pkg::PORT_32;
        void'($urandom(32'hc6f1_5023));
        for (int i = 0; i < MEM_BYTES; i++)
            mem[i] = 8'($urandom);

        // Reads first, then writes, over every port, size and offset.
        idx = 0;
        for (int rw = 1; rw >= 0; rw--)
            for (int p = 0; p < 3; p++)
                for (int s = 0; s < 4; s++)
                    for (int o = 0; o < 4; o++) begin
                        rows[idx].addr  = 24'(((idx * 4) % 56) + o);
                        rows[idx].size  = 2'(s);
                        rows[idx].rw    = 1'(rw);
                        rows[idx].wdata = $urandom;
                        rows[idx].port  = ports[p];
                        rows[idx].berr  = 1'b0;
                        idx++;
                    end
        rows[idx] = '{24'd8, 2'd3, 1'b1, 32'd0, bridge_pkg::PORT_16, 1'b1, 32'd0};
        for (int i = 0; i < NUM_ROWS; i++) begin
            rows[i].expected = rows[i].wdata & (32'hffff_ffff >> (8 * (3 - int'(rows[i].size))));
            if (rows[i].rw) begin
                rows[i].expected = '0;   // Big-endian bytes from memory.
                for (int j = 0; j <= int'(rows[i].size); j++)
                    rows[i].expected = (rows[i].expected << 8) | mem[int'(rows[i].addr) + j];
            end
        end

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check("mc_reset_n_oe", {31'd0, mc_reset_n_oe}, 32'd1);
        check("mc_halt_n_oe", {31'd0, mc_halt_n_oe}, 32'd1);
        check("mc_as_n", {31'd0, mc_as_n}, 32'd1);
        check("mc_ds_n", {31'd0, mc_ds_n}, 32'd1);
        check("mc_data_oe", {31'd0, mc_data_oe}, 32'd0);
        check("mc_bus_oe", {31'd0, mc_bus_oe}, 32'd0);
        check("mc_br_n", {31'd0, mc_br_n}, 32'd1);
        check("int2_n_oe", {31'd0, int2_n_oe}, 32'd0);
        check("int6_n_oe", {31'd0, int6_n_oe}, 32'd0);
        pi_access(1'b1, bridge_pkg::REG_STATUS, 16'h0006, q);
        check("mc_reset_n_oe", {31'd0, mc_reset_n_oe}, 32'd0);
        check("mc_halt_n_oe", {31'd0, mc_halt_n_oe}, 32'd0);
        pi_access(1'b1, bridge_pkg::REG_STATUS, 16'h8018, q);
        check("int2_n_oe", {31'd0, int2_n_oe}, 32'd1);
        check("int6_n_oe", {31'd0, int6_n_oe}, 32'd1);

        pi_access(1'b1, bridge_pkg::REG_STATUS, 16'h8001, q);
        do
            pi_access(1'b0, bridge_pkg::REG_STATUS, 16'h0000, q);
        while (!q[0]);
        check("mc_bus_oe", {31'd0, mc_bus_oe}, 32'd1);
        check("mc_br_n", {31'd0, mc_br_n}, 32'd0);

        for (int i = 0; i < NUM_ROWS; i++)
            run_row(rows[i]);

        $display("All tests passed");
        $finish;
    end

endmodule

// File: verilog.f
logic/bridge_pkg.sv
logic/bus_sampler.sv
logic/pi_regs.sv
logic/write_steer.sv
logic/access_fsm.sv
logic/read_merge.sv
logic/pistorm_bridge.sv
test/pistorm_bridge_assert.sv
test/tb_pistorm_bridge.sv
